/* verilog.f */
src/queue_cfg_pkg.sv
src/queue_types_pkg.sv
src/page_allocator.sv
src/queue_pointer_table.sv
src/queue_memory.sv
src/packet_queue_top.sv
dv/packet_queue_tb.sv

/* Bender.yml */
package:
  name: packet_queue

sources:
  # Packages first, then RTL from the leaves up
  - src/queue_cfg_pkg.sv
  - src/queue_types_pkg.sv
  - src/page_allocator.sv
  - src/queue_pointer_table.sv
  - src/queue_memory.sv
  - src/packet_queue_top.sv
  - target: test
    files:
      - dv/packet_queue_tb.sv

/* dv/packet_queue_tb.sv */
// Testbench for the paged packet queue with seeded random traffic,
// a per-queue model of expected words, output and mask checks
`timescale 1ns/1ps

module packet_queue_tb;

    import queue_cfg_pkg::*;
    import queue_types_pkg::*;

    localparam int num_requests  = 600;
    localparam int max_pkt_words = 9;
    // At 20 stored words the queues hold at most 16 pages with tail and spare
    localparam int max_stored    = 20;
    // About 30 cycles per request covers the random gaps
    localparam int timeout_cycles = num_requests * 30 + 2000;
    localparam int model_depth   = 64;

    typedef struct packed {
        logic [queue_w-1:0]    qid;
        logic [data_w-1:0]     data;
        logic [data_bytes-1:0] keep;
        logic                  last;
    } exp_word_t;

    logic                  packet_in = 1'b0;
    logic                  arst_n;
    enq_word_t             enq;
    deq_req_t              deq_req;
    deq_word_t             deq_word;
    deq_note_t             deq_note;
    logic [num_queues-1:0] nonempty;

    // Per-queue expected words, and requested words in request order
    exp_word_t          model_mem [num_queues][model_depth];
    int                 model_wr [num_queues];
    int                 model_rd [num_queues];
    exp_word_t          inflight [num_requests];
    int                 inflight_wr, word_rd, note_rd;
    int                 enq_total, words_out, edges_since_req, pkt_left;
    logic [queue_w-1:0] pkt_q;
    int                 cycle_cnt = 0;

    packet_queue_top uut (
        .packet_in (packet_in),
        .arst_n    (arst_n),
        .enq       (enq),
        .deq_req   (deq_req),
        .deq_word  (deq_word),
        .deq_note  (deq_note),
        .nonempty  (nonempty)
    );

    always #10 packet_in = ~packet_in;

    task automatic report_failure();
        $display("Checks failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_equal(input string test_name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (expected === actual) else begin
            $display("mismatch %s: expected %h, actual %h", test_name, expected, actual);
            report_failure();
        end
    endtask

    //////////////////////////////////////////////////
    // Per-cycle checks

    task automatic check_outputs();
        exp_word_t exp;
        logic [num_queues-1:0] exp_mask;
        if (deq_word.valid) begin
            assert (word_rd < inflight_wr) else begin
                $display("output word arrived with no request outstanding");
                report_failure();
            end
            exp = inflight[word_rd];
            check_equal("word_data", exp.data, deq_word.data);
            check_equal("word_keep", exp.keep, deq_word.keep);
            check_equal("word_last", exp.last, deq_word.last);
            check_equal("egress_port", exp.qid / queues_per_port, deq_word.port);
            word_rd++;
            words_out++;
        end
        if (deq_note.valid) begin
            assert (note_rd < inflight_wr) else begin
                $display("notification arrived with no request outstanding");
                report_failure();
            end
            exp = inflight[note_rd];
            check_equal("note_qid", exp.qid, deq_note.qid);
            check_equal("note_bytes", $countones(exp.keep), deq_note.bytes);
            check_equal("note_last", exp.last, deq_note.last);
            note_rd++;
        end
        // Table has answered every request by now
        if (edges_since_req >= 2) begin
            for (int q = 0; q < num_queues; q++) begin
                exp_mask[q] = model_wr[q] != model_rd[q];
            end
            check_equal("nonempty_mask", exp_mask, nonempty);
        end
    endtask

    task automatic step();
        @(negedge packet_in);
        if (edges_since_req < 1000) begin
            edges_since_req++;
        end
        check_outputs();
        enq     = '0;
        deq_req = '0;
    endtask

    //////////////////////////////////////////////////
    // Stimulus

    task automatic send_request();
        int start;
        int q;
        start = $urandom % num_queues;
        for (int i = 0; i < num_queues; i++) begin
            q = (start + i) % num_queues;
            if (!deq_req.valid && model_wr[q] != model_rd[q]) begin
                inflight[inflight_wr] = model_mem[q][model_rd[q] % model_depth];
                inflight_wr++;
                model_rd[q]++;
                deq_req         = '{valid: 1'b1, qid: queue_w'(q)};
                edges_since_req = 0;
            end
        end
    endtask

    task automatic send_enqueue();
        int len;
        exp_word_t w;
        if (pkt_left == 0 && enq_total < num_requests && $urandom % 2 == 0) begin
            len = 1 + $urandom % max_pkt_words;
            if (len > num_requests - enq_total) begin
                len = num_requests - enq_total;
            end
            if (enq_total - words_out + len <= max_stored) begin
                pkt_left = len;
                pkt_q    = queue_w'($urandom % num_queues);
            end
        end
        if (pkt_left > 0 && $urandom % 4 != 0) begin
            w.qid  = pkt_q;
            w.data = {$urandom, $urandom};
            w.last = pkt_left == 1;
            // Last word keeps a prefix of 1 to 8 bytes
            w.keep = w.last ? data_bytes'((1 << (1 + $urandom % data_bytes)) - 1) : '1;
            enq    = '{valid: 1'b1, qid: w.qid, data: w.data, keep: w.keep, last: w.last};
            model_mem[pkt_q][model_wr[pkt_q] % model_depth] = w;
            model_wr[pkt_q]++;
            pkt_left--;
            enq_total++;
        end
    endtask

    always @(posedge packet_in) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: traffic still running after %0d cycles", cycle_cnt);
            report_failure();
        end
    end

    initial begin
        void'($urandom(76386));
        arst_n          = 1'b0;
        enq             = '0;
        deq_req         = '0;
        inflight_wr     = 0;
        word_rd         = 0;
        note_rd         = 0;
        enq_total       = 0;
        words_out       = 0;
        pkt_left        = 0;
        pkt_q           = '0;
        edges_since_req = 1000;
        for (int q = 0; q < num_queues; q++) begin
            model_wr[q] = 0;
            model_rd[q] = 0;
        end
        repeat (8) @(posedge packet_in);
        @(negedge packet_in);
        arst_n = 1'b1;
        step();
        check_equal("reset_nonempty", 0, nonempty);
        check_equal("reset_word_valid", 0, deq_word.valid);
        check_equal("reset_note_valid", 0, deq_note.valid);

        while (inflight_wr < num_requests) begin
            step();
            if ($urandom % 2 == 0) begin
                send_request();
            end
            send_enqueue();
        end
        while (word_rd < inflight_wr || note_rd < inflight_wr) begin
            step();
        end
        repeat (2) step();
        check_equal("drain_nonempty", 0, nonempty);
        $display("All checks passed");
        $finish;
    end

endmodule

/* src/packet_queue_top.sv */
// Paged packet queue with pointer table, page allocator and queue memory
`timescale 1ns/1ps

module packet_queue_top (
    input  logic                                packet_in,
    input  logic                                arst_n,
    input  queue_types_pkg::enq_word_t          enq,
    input  queue_types_pkg::deq_req_t           deq_req,
    output queue_types_pkg::deq_word_t          deq_word,
    output queue_types_pkg::deq_note_t          deq_note,
    output logic [queue_cfg_pkg::num_queues-1:0] nonempty
);

    import queue_types_pkg::*;

    enq_meta_t enq_meta;
    axil_ar_t  ar;
    axil_r_t   r;
    logic      alloc_req;
    page_msg_t grant;
    page_msg_t page_free;

    queue_pointer_table u_table (
        .packet_in (packet_in),
        .arst_n    (arst_n),
        .enq       (enq),
        .enq_meta  (enq_meta),
        .ar        (ar),
        .r         (r),
        .alloc_req (alloc_req),
        .grant     (grant),
        .nonempty  (nonempty)
    );

    page_allocator u_alloc (
        .packet_in (packet_in),
        .arst_n    (arst_n),
        .alloc_req (alloc_req),
        .grant     (grant),
        .page_free (page_free)
    );

    queue_memory u_mem (
        .packet_in (packet_in),
        .arst_n    (arst_n),
        .enq       (enq),
        .enq_meta  (enq_meta),
        .deq_req   (deq_req),
        .ar        (ar),
        .r         (r),
        .deq_word  (deq_word),
        .deq_note  (deq_note),
        .page_free (page_free)
    );

endmodule

/* src/queue_memory.sv */
// Word store and length store with the enqueue write pipeline and the
// dequeue read pipeline
`timescale 1ns/1ps

module queue_memory (
    input  logic                        packet_in,
    input  logic                        arst_n,
    input  queue_types_pkg::enq_word_t  enq,
    input  queue_types_pkg::enq_meta_t  enq_meta,
    input  queue_types_pkg::deq_req_t   deq_req,
    output queue_types_pkg::axil_ar_t   ar,
    input  queue_types_pkg::axil_r_t    r,
    output queue_types_pkg::deq_word_t  deq_word,
    output queue_types_pkg::deq_note_t  deq_note,
    output queue_types_pkg::page_msg_t  page_free
);

    import queue_cfg_pkg::*;
    import queue_types_pkg::*;

    localparam logic [offset_w-1:0] last_off = offset_w'(words_per_page - 1);

    typedef struct packed {
        logic [keep_enc_w-1:0] keep_enc;
        logic                  last;
    } len_entry_t;

    //////////////////////////////////////////////////
    // Keep coding

    // Index of the first zero byte, full keep gives zero
    function automatic logic [keep_enc_w-1:0] encode_keep(input logic [data_bytes-1:0] keep);
        logic [keep_enc_w-1:0] enc;
        enc = '0;
        for (int i = data_bytes - 1; i >= 1; i--) begin
            if (!keep[i]) begin
                enc = keep_enc_w'(i);
            end
        end
        return enc;
    endfunction

    function automatic logic [data_bytes-1:0] decode_keep(input logic [keep_enc_w-1:0] enc);
        return (enc == '0) ? '1 : data_bytes'((1 << enc) - 1);
    endfunction

    function automatic logic [bytes_w-1:0] keep_bytes(input logic [keep_enc_w-1:0] enc);
        return (enc == '0) ? bytes_w'(data_bytes) : bytes_w'(enc);
    endfunction

    logic [data_w-1:0] word_mem [queue_mem_depth];
    len_entry_t        len_mem  [queue_mem_depth];

    // Enqueue pipeline
    logic                sop;
    logic                wr_en;
    logic [addr_w-1:0]   wr_addr;
    logic [data_w-1:0]   wr_data;
    len_entry_t          wr_len;
    logic [page_w-1:0]   cur_page;
    logic [page_w-1:0]   next_page;
    logic [offset_w-1:0] wr_off;

    // Dequeue pipeline
    head_ptr_t          head;
    logic               rd_ok;
    logic [addr_w-1:0]  rd_addr;
    logic [queue_w-1:0] qid_d [4];
    logic               rd_v1;
    logic               rd_v2;
    logic [data_w-1:0]  data_do;
    logic [data_w-1:0]  data_res;
    len_entry_t         len_do;
    len_entry_t         len_res;

    //////////////////////////////////////////////////
    // Enqueue

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            sop   <= 1'b1;
            wr_en <= 1'b0;
        end else begin
            wr_en <= enq.valid;
            if (enq.valid) begin
                sop <= enq.last;
            end
        end
    end

    always_ff @(posedge packet_in) begin
        // Stage 1 address and payload
        wr_data <= enq.data;
        wr_len  <= '{keep_enc: encode_keep(enq.keep), last: enq.last};
        if (enq.valid) begin
            // Spare page refreshed every word, as the table swaps it on a crossing
            next_page <= enq_meta.next_page;
            if (sop) begin
                wr_addr <= {enq_meta.cur_page, enq_meta.tail_off};
                wr_off  <= enq_meta.tail_off + 1'b1;
                if (enq_meta.tail_off == last_off) begin
                    cur_page <= enq_meta.next_page;
                end else begin
                    cur_page <= enq_meta.cur_page;
                end
            end else begin
                wr_addr <= {cur_page, wr_off};
                wr_off  <= wr_off + 1'b1;
                if (wr_off == last_off) begin
                    cur_page <= next_page;
                end
            end
        end
        // Stage 2 store write
        if (wr_en) begin
            word_mem[wr_addr] <= wr_data;
            len_mem[wr_addr]  <= wr_len;
        end
    end

    //////////////////////////////////////////////////
    // Dequeue

    assign head    = head_ptr_t'(r.rdata[$bits(head_ptr_t)-1:0]);
    assign rd_ok   = r.rvalid && (r.rresp == resp_okay);
    assign rd_addr = {head.page, head.offset};

    // Head leaves its page on the last offset
    assign page_free = '{valid: rd_ok && (head.offset == last_off), page: head.page};

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            ar       <= '0;
            rd_v1    <= 1'b0;
            rd_v2    <= 1'b0;
            deq_note <= '0;
            deq_word <= '0;
        end else begin
            ar.arvalid <= deq_req.valid;
            ar.araddr  <= axil_addr_w'(deq_req.qid);

            rd_v1 <= rd_ok;
            rd_v2 <= rd_v1;

            // Notification from the length store
            deq_note.valid <= rd_v1;
            deq_note.qid   <= qid_d[2];
            deq_note.bytes <= keep_bytes(len_do.keep_enc);
            deq_note.last  <= len_do.last;

            // Output word after the extra data register
            deq_word.valid <= rd_v2;
            deq_word.data  <= data_res;
            deq_word.keep  <= decode_keep(len_res.keep_enc);
            deq_word.last  <= len_res.last;
            deq_word.port  <= port_w'(qid_d[3] / queues_per_port);
        end
    end

    always_ff @(posedge packet_in) begin
        qid_d[0] <= deq_req.qid;
        qid_d[1] <= qid_d[0];
        qid_d[2] <= qid_d[1];
        qid_d[3] <= qid_d[2];

        // Store reads on the response cycle
        data_do <= word_mem[rd_addr];
        len_do  <= len_mem[rd_addr];

        data_res <= data_do;
        len_res  <= len_do;
    end

endmodule

/* src/queue_pointer_table.sv */
// Per-queue head, tail and spare pages, page links, and the AXI4-Lite
// read slave for head pointers
`timescale 1ns/1ps

module queue_pointer_table (
    input  logic                                packet_in,
    input  logic                                arst_n,
    input  queue_types_pkg::enq_word_t          enq,
    output queue_types_pkg::enq_meta_t          enq_meta,
    input  queue_types_pkg::axil_ar_t           ar,
    output queue_types_pkg::axil_r_t            r,
    output logic                                alloc_req,
    input  queue_types_pkg::page_msg_t          grant,
    output logic [queue_cfg_pkg::num_queues-1:0] nonempty
);

    import queue_cfg_pkg::*;
    import queue_types_pkg::*;

    localparam logic [offset_w-1:0] last_off = offset_w'(words_per_page - 1);

    // Queue state
    logic [page_w-1:0]   tail_page  [num_queues];
    logic [offset_w-1:0] tail_off   [num_queues];
    logic [page_w-1:0]   spare_page [num_queues];
    logic [page_w-1:0]   head_page  [num_queues];
    logic [offset_w-1:0] head_off   [num_queues];
    logic [count_w-1:0]  word_cnt   [num_queues];

    // Next page of every page in use
    logic [page_w-1:0] page_link [num_pages];

    logic                  sop;
    logic [queue_w-1:0]    pkt_q;
    logic [queue_w-1:0]    enq_q;
    logic                  rd_hit;
    logic [queue_w-1:0]    rd_q;
    head_ptr_t             head_rd;
    logic [num_queues-1:0] cnt_inc;
    logic [num_queues-1:0] cnt_dec;

    //////////////////////////////////////////////////
    // Enqueue side

    // Queue id is taken from the first word of a packet
    assign enq_q = sop ? enq.qid : pkt_q;

    assign enq_meta = '{
        cur_page:  tail_page[enq_q],
        tail_off:  tail_off[enq_q],
        next_page: spare_page[enq_q]
    };

    // Tail leaves its page with this word
    assign alloc_req = enq.valid && (tail_off[enq_q] == last_off);

    //////////////////////////////////////////////////
    // Head pointer reads

    assign rd_hit  = ar.arvalid && (ar.araddr < num_queues);
    assign rd_q    = ar.araddr[queue_w-1:0];
    assign head_rd = '{page: head_page[rd_q], offset: head_off[rd_q]};

    always_comb begin
        for (int q = 0; q < num_queues; q++) begin
            cnt_inc[q]  = enq.valid && (enq_q == queue_w'(q));
            cnt_dec[q]  = rd_hit && (rd_q == queue_w'(q));
            nonempty[q] = word_cnt[q] != '0;
        end
    end

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            sop   <= 1'b1;
            pkt_q <= '0;
            r     <= '0;
            for (int q = 0; q < num_queues; q++) begin
                tail_page[q]  <= page_w'(q);
                tail_off[q]   <= '0;
                spare_page[q] <= page_w'(q + num_queues);
                head_page[q]  <= page_w'(q);
                head_off[q]   <= '0;
                word_cnt[q]   <= '0;
            end
        end else begin
            // Tail advance
            if (enq.valid) begin
                sop <= enq.last;
                if (sop) begin
                    pkt_q <= enq.qid;
                end
                if (alloc_req) begin
                    tail_page[enq_q]  <= spare_page[enq_q];
                    spare_page[enq_q] <= grant.page;
                end
                tail_off[enq_q] <= tail_off[enq_q] + 1'b1;
            end

            // Response one cycle after the request
            r.rvalid <= ar.arvalid;
            r.rresp  <= rd_hit ? resp_okay : resp_slverr;
            r.rdata  <= rd_hit ? axil_data_w'(head_rd) : '0;

            // Head advance, following the link at the end of a page
            if (rd_hit) begin
                if (head_off[rd_q] == last_off) begin
                    head_page[rd_q] <= page_link[head_page[rd_q]];
                end
                head_off[rd_q] <= head_off[rd_q] + 1'b1;
            end

            for (int q = 0; q < num_queues; q++) begin
                if (cnt_inc[q] && !cnt_dec[q]) begin
                    word_cnt[q] <= word_cnt[q] + 1'b1;
                end else if (cnt_dec[q] && !cnt_inc[q]) begin
                    word_cnt[q] <= word_cnt[q] - 1'b1;
                end
            end
        end
    end

    // Old tail page points at the spare it moves to
    always_ff @(posedge packet_in) begin
        if (alloc_req) begin
            page_link[tail_page[enq_q]] <= spare_page[enq_q];
        end
    end

endmodule

/* src/page_allocator.sv */
// Free-page list of the queue memory
`timescale 1ns/1ps

module page_allocator (
    input  logic                        packet_in,
    input  logic                        arst_n,
    input  logic                        alloc_req,
    output queue_types_pkg::page_msg_t  grant,
    input  queue_types_pkg::page_msg_t  page_free
);

    import queue_cfg_pkg::*;

    logic [page_w-1:0] free_fifo [num_pages];
    logic [page_w-1:0] rd_idx;
    logic [page_w-1:0] wr_idx;
    logic [page_w:0]   free_cnt;
    logic              pop;
    logic              push;

    //////////////////////////////////////////////////
    // Grant and handshake

    // Grant is offered whenever the list holds a page
    assign grant = '{valid: free_cnt != '0, page: free_fifo[rd_idx]};

    assign pop  = alloc_req && (free_cnt != '0);
    assign push = page_free.valid;

    //////////////////////////////////////////////////
    // Circular list

    always_ff @(posedge packet_in or negedge arst_n) begin
        if (!arst_n) begin
            // Pages above the owned ones start out free
            for (int i = 0; i < num_pages; i++) begin
                free_fifo[i] <= page_w'(i + owned_pages);
            end
            rd_idx   <= '0;
            wr_idx   <= page_w'(num_pages - owned_pages);
            free_cnt <= (page_w + 1)'(num_pages - owned_pages);
        end else begin
            if (push) begin
                free_fifo[wr_idx] <= page_free.page;
                wr_idx            <= wr_idx + 1'b1;
            end
            if (pop) begin
                rd_idx <= rd_idx + 1'b1;
            end
            // Push and pop together leave the count alone
            if (push && !pop) begin
                free_cnt <= free_cnt + 1'b1;
            end else if (pop && !push) begin
                free_cnt <= free_cnt - 1'b1;
            end
        end
    end

endmodule

/* src/queue_types_pkg.sv */
// Stream words, packet metadata, head pointers, AXI4-Lite read channel
// and page messages of the queue memory
package queue_types_pkg;

    // Enqueue stream word
    typedef struct packed {
        logic                                   valid;
        logic [queue_cfg_pkg::queue_w-1:0]      qid;
        logic [queue_cfg_pkg::data_w-1:0]       data;
        logic [queue_cfg_pkg::data_bytes-1:0]   keep;
        logic                                   last;
    } enq_word_t;

    // Start position of a packet, from the pointer table
    typedef struct packed {
        logic [queue_cfg_pkg::page_w-1:0]   cur_page;
        logic [queue_cfg_pkg::offset_w-1:0] tail_off;
        logic [queue_cfg_pkg::page_w-1:0]   next_page;
    } enq_meta_t;

    // Carried in the low bits of rdata
    typedef struct packed {
        logic [queue_cfg_pkg::page_w-1:0]   page;
        logic [queue_cfg_pkg::offset_w-1:0] offset;
    } head_ptr_t;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axil_resp_e;

    typedef struct packed {
        logic                                   arvalid;
        logic [queue_cfg_pkg::axil_addr_w-1:0]  araddr;
    } axil_ar_t;

    typedef struct packed {
        logic                                   rvalid;
        logic [queue_cfg_pkg::axil_data_w-1:0]  rdata;
        axil_resp_e                             rresp;
    } axil_r_t;

    // Scheduler request for one word
    typedef struct packed {
        logic                               valid;
        logic [queue_cfg_pkg::queue_w-1:0]  qid;
    } deq_req_t;

    typedef struct packed {
        logic                                   valid;
        logic [queue_cfg_pkg::data_w-1:0]       data;
        logic [queue_cfg_pkg::data_bytes-1:0]   keep;
        logic                                   last;
        logic [queue_cfg_pkg::port_w-1:0]       port;
    } deq_word_t;

    // Byte count runs 1 to data_bytes
    typedef struct packed {
        logic                               valid;
        logic [queue_cfg_pkg::queue_w-1:0]  qid;
        logic [queue_cfg_pkg::bytes_w-1:0]  bytes;
        logic                               last;
    } deq_note_t;

    // Page free or page grant
    typedef struct packed {
        logic                               valid;
        logic [queue_cfg_pkg::page_w-1:0]   page;
    } page_msg_t;

endpackage

/* src/queue_cfg_pkg.sv */
// Sizes of the paged queue memory and the widths derived from them
package queue_cfg_pkg;

    // Base sizes
    localparam int data_bytes       = 8;
    localparam int words_per_page   = 4;
    localparam int num_pages        = 16;
    localparam int num_queues       = 4;
    localparam int queues_per_port  = 2;
    localparam int num_egress_ports = 2;
    localparam int queue_mem_depth  = num_pages * words_per_page;

    // Each queue starts with a tail page and a spare page
    localparam int owned_pages = 2 * num_queues;

    // Index widths
    localparam int offset_w   = $clog2(words_per_page);
    localparam int page_w     = $clog2(num_pages);
    localparam int queue_w    = $clog2(num_queues);
    localparam int port_w     = $clog2(num_egress_ports);
    localparam int keep_enc_w = $clog2(data_bytes);

    // Derived widths
    localparam int addr_w  = page_w + offset_w;
    localparam int data_w  = 8 * data_bytes;
    localparam int bytes_w = keep_enc_w + 1;
    localparam int count_w = $clog2(queue_mem_depth) + 1;

    // AXI4-Lite head pointer channel
    localparam int axil_addr_w = 32;
    localparam int axil_data_w = 32;

endpackage
